// ==== hdl/core_fsm.sv ====
/*
 * Core mode state machine.
 * Start enters programming mode, the first data line at the input
 * FIFO head switches the core to processing mode.
 */
`default_nettype none

module core_fsm (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire head_valid,
	input wire head_is_data,
	output dt_core_pkg::core_mode_e mode
);

	dt_core_pkg::core_mode_e state_q;
	dt_core_pkg::core_mode_e state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			dt_core_pkg::PROG_MODE: begin
				// Trees are loaded once tuple data shows up
				if (head_valid && head_is_data) begin
					state_d = dt_core_pkg::PROCESS_MODE;
				end
			end
			default: begin
				state_d = state_q;
			end
		endcase
		// A new start always restarts programming, whatever the state
		if (start) begin
			state_d = dt_core_pkg::PROG_MODE;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= dt_core_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign mode = state_q;

endmodule

`default_nettype wire

// ==== hdl/dt_core.sv ====
/*
 * Decision-tree inference core, top level.
 * Input FIFO, mode FSM, schedule rotator, line distributor toward the
 * cluster lanes, and the result gatherer with its output FIFO.
 */
`default_nettype none

module dt_core (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire dt_core_pkg::core_cfg_t cfg,
	input wire dt_core_pkg::core_line_t in_line,
	input wire in_valid,
	output logic in_ready,
	output dt_core_pkg::lane_beat_t [dt_core_pkg::NUM_CLUSTERS-1:0] lanes,
	input wire dt_core_pkg::cluster_mask_t lane_ready,
	input wire dt_core_pkg::partial_t [dt_core_pkg::NUM_CLUSTERS-1:0] partials,
	output dt_core_pkg::cluster_mask_t partial_ready,
	output logic [dt_core_pkg::RESULT_W-1:0] tuple_out,
	output logic tuple_out_valid,
	input wire tuple_out_ready
);

	dt_core_pkg::core_line_t head;
	dt_core_pkg::core_mode_e mode;
	dt_core_pkg::cluster_mask_t mask;
	logic in_full;
	logic in_empty;
	logic head_valid;
	logic pop;
	logic tree_done;
	logic tuple_done;
	logic [dt_core_pkg::RESULT_W-1:0] sum;
	logic sum_push;
	logic out_full;
	logic out_empty;

	assign in_ready = ~in_full;
	assign head_valid = ~in_empty;
	assign tuple_out_valid = ~out_empty;

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////

	stream_fifo #(
		.payload_t(dt_core_pkg::core_line_t),
		.DEPTH(dt_core_pkg::IN_FIFO_DEPTH)
	) in_fifo (
		.clk(clk), .rst_n(rst_n),
		.din(in_line), .push(in_valid), .full(in_full),
		.dout(head), .pop(pop), .empty(in_empty)
	);

	core_fsm fsm (
		.clk(clk), .rst_n(rst_n), .start(start),
		.head_valid(head_valid), .head_is_data(head.is_data), .mode(mode)
	);

	schedule_rotator rotator (
		.clk(clk), .rst_n(rst_n), .start(start), .mode(mode), .cfg(cfg),
		.tree_done(tree_done), .tuple_done(tuple_done), .mask(mask)
	);

	line_distributor distributor (
		.clk(clk), .rst_n(rst_n), .mode(mode),
		.head(head), .head_valid(head_valid), .pop(pop),
		.mask(mask), .lane_ready(lane_ready),
		.tree_done(tree_done), .tuple_done(tuple_done), .lanes(lanes)
	);

	////////////////////////////////////////
	// Output side
	////////////////////////////////////////

	result_gatherer gatherer (
		.clk(clk), .rst_n(rst_n), .start(start), .cfg(cfg),
		.partials(partials), .partial_ready(partial_ready),
		.sum(sum), .sum_push(sum_push), .out_full(out_full)
	);

	stream_fifo #(
		.payload_t(logic [dt_core_pkg::RESULT_W-1:0]),
		.DEPTH(dt_core_pkg::OUT_FIFO_DEPTH)
	) out_fifo (
		.clk(clk), .rst_n(rst_n),
		.din(sum), .push(sum_push), .full(out_full),
		.dout(tuple_out), .pop(tuple_out_ready), .empty(out_empty)
	);

endmodule

`default_nettype wire

// ==== hdl/dt_core_pkg.sv ====
/*
 * Decision-tree core shared definitions.
 * Widths, counts and the packed structs that travel between blocks.
 */
`default_nettype none

package dt_core_pkg;

	localparam int NUM_CLUSTERS = 4;
	localparam int CLUSTER_IDX_W = 2;
	localparam int LINE_W = 64;
	localparam int HALF_W = 32;
	localparam int RESULT_W = 32;
	localparam int PUS_PER_CLUSTER = 2;
	localparam int TREE_CNT_W = 1;
	localparam int IN_FIFO_DEPTH = 8;
	localparam int OUT_FIFO_DEPTH = 4;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		PROG_MODE = 2'd1,
		PROCESS_MODE = 2'd2
	} core_mode_e;

	// One input line, either tree programming words or tuple data
	typedef struct packed {
		logic [LINE_W-1:0] data;
		logic is_data;
		logic last;
	} core_line_t;

	typedef struct packed {
		logic [HALF_W-1:0] half;
		logic valid;
		logic is_data;
		logic last;
	} lane_beat_t;

	typedef logic [NUM_CLUSTERS-1:0] cluster_mask_t;

	typedef struct packed {
		logic [NUM_CLUSTERS-1:0] prog_schedule;
		logic [NUM_CLUSTERS-1:0] proc_schedule;
		logic [2:0] clusters_per_tuple; // 1 to 4
	} core_cfg_t;

	typedef struct packed {
		logic [RESULT_W-1:0] value;
		logic valid;
	} partial_t;

endpackage

`default_nettype wire

// ==== hdl/line_distributor.sv ====
/*
 * Line distributor.
 * Splits each 64-bit line into two halves, low half first, and
 * broadcasts them to all cluster lanes with the current enable mask.
 */
`default_nettype none

module line_distributor (
	input wire clk,
	input wire rst_n,
	input wire dt_core_pkg::core_mode_e mode,
	input wire dt_core_pkg::core_line_t head,
	input wire head_valid,
	output logic pop,
	input wire dt_core_pkg::cluster_mask_t mask,
	input wire dt_core_pkg::cluster_mask_t lane_ready,
	output logic tree_done,
	output logic tuple_done,
	output dt_core_pkg::lane_beat_t [dt_core_pkg::NUM_CLUSTERS-1:0] lanes
);

	logic half_sel;
	logic target_ready;
	logic line_ok;
	logic send;
	logic [dt_core_pkg::HALF_W-1:0] half_q;
	logic valid_q;
	logic is_data_q;
	logic last_q;
	dt_core_pkg::cluster_mask_t en_q;

	assign target_ready = |(lane_ready & mask);

	// Programming halves never wait, data halves need an enabled cluster ready
	always_comb begin
		line_ok = 1'b1;
		if (head.is_data) begin
			line_ok = (mode == dt_core_pkg::PROCESS_MODE) && target_ready;
		end
	end

	assign send = head_valid && (mode != dt_core_pkg::IDLE) && line_ok;
	assign pop = send & half_sel;
	assign tree_done = pop & head.last & ~head.is_data;
	assign tuple_done = pop & head.last & head.is_data;

	////////////////////////////////////////
	// Broadcast stage
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			half_sel <= 1'b0;
			valid_q <= 1'b0;
			is_data_q <= 1'b0;
			last_q <= 1'b0;
			en_q <= '0;
		end else begin
			if (send) begin
				half_sel <= ~half_sel;
			end
			valid_q <= send;
			is_data_q <= send & head.is_data;
			last_q <= send & head.last & half_sel;
			en_q <= mask;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			half_q <= half_sel ? head.data[dt_core_pkg::LINE_W-1:dt_core_pkg::HALF_W]
				: head.data[dt_core_pkg::HALF_W-1:0];
		end
	end

	always_comb begin
		for (int c = 0; c < dt_core_pkg::NUM_CLUSTERS; c++) begin
			lanes[c].half = half_q;
			lanes[c].valid = valid_q & en_q[c];
			lanes[c].is_data = is_data_q;
			lanes[c].last = last_q & en_q[c];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/result_gatherer.sv ====
/*
 * Result gatherer.
 * Takes one partial per cluster of a tuple, visiting the clusters from a
 * rotating base, and pushes the integer sum to the output FIFO.
 */
`default_nettype none

module result_gatherer (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire dt_core_pkg::core_cfg_t cfg,
	input wire dt_core_pkg::partial_t [dt_core_pkg::NUM_CLUSTERS-1:0] partials,
	output dt_core_pkg::cluster_mask_t partial_ready,
	output logic [dt_core_pkg::RESULT_W-1:0] sum,
	output logic sum_push,
	input wire out_full
);

	logic active;
	logic [dt_core_pkg::CLUSTER_IDX_W-1:0] base;
	logic [dt_core_pkg::CLUSTER_IDX_W-1:0] offset;
	logic [dt_core_pkg::CLUSTER_IDX_W-1:0] sel;
	logic [dt_core_pkg::RESULT_W-1:0] acc;
	logic take;
	logic tuple_end;

	// Cluster index wraps modulo NUM_CLUSTERS by its width
	assign sel = base + offset;

	// Only the selected cluster is offered a ready, and none while the output is full
	always_comb begin
		partial_ready = '0;
		if (active && !out_full) begin
			partial_ready[sel] = 1'b1;
		end
	end

	assign take = partial_ready[sel] & partials[sel].valid;
	assign tuple_end = ({1'b0, offset} == cfg.clusters_per_tuple - 3'd1);
	assign sum = acc + partials[sel].value;
	assign sum_push = take & tuple_end;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			base <= '0;
			offset <= '0;
			acc <= '0;
		end else if (start) begin
			active <= 1'b1;
			base <= '0;
			offset <= '0;
			acc <= '0;
		end else if (take) begin
			if (tuple_end) begin
				acc <= '0;
				offset <= '0;
				base <= base + cfg.clusters_per_tuple[dt_core_pkg::CLUSTER_IDX_W-1:0];
			end else begin
				acc <= sum;
				offset <= offset + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/schedule_rotator.sv ====
/*
 * Cluster schedule rotator.
 * Holds the enable mask for the lanes, rotates it after every
 * PUS_PER_CLUSTER trees in programming and after every tuple in processing.
 */
`default_nettype none

module schedule_rotator (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire dt_core_pkg::core_mode_e mode,
	input wire dt_core_pkg::core_cfg_t cfg,
	input wire tree_done,
	input wire tuple_done,
	output dt_core_pkg::cluster_mask_t mask
);

	dt_core_pkg::cluster_mask_t mask_q;
	logic [dt_core_pkg::TREE_CNT_W-1:0] tree_cnt;
	logic proc_q;

	// Rotate left by n places, n from 0 to NUM_CLUSTERS
	function automatic dt_core_pkg::cluster_mask_t rotl(input dt_core_pkg::cluster_mask_t m,
			input logic [2:0] n);
		logic [2*dt_core_pkg::NUM_CLUSTERS-1:0] dbl;
		dbl = {m, m} << n;
		return dbl[2*dt_core_pkg::NUM_CLUSTERS-1 -: dt_core_pkg::NUM_CLUSTERS];
	endfunction

	// The first data line of processing mode sees the configured schedule directly
	assign mask = (mode == dt_core_pkg::PROCESS_MODE && !proc_q) ? cfg.proc_schedule : mask_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mask_q <= '0;
			tree_cnt <= '0;
			proc_q <= 1'b0;
		end else if (start) begin
			mask_q <= cfg.prog_schedule;
			tree_cnt <= '0;
			proc_q <= 1'b0;
		end else if (mode == dt_core_pkg::PROCESS_MODE) begin
			proc_q <= 1'b1;
			if (tuple_done) begin
				mask_q <= rotl(mask, cfg.clusters_per_tuple);
			end else if (!proc_q) begin
				mask_q <= cfg.proc_schedule;
			end
		end else if (tree_done) begin
			if (tree_cnt == dt_core_pkg::TREE_CNT_W'(dt_core_pkg::PUS_PER_CLUSTER - 1)) begin
				tree_cnt <= '0;
				mask_q <= rotl(mask_q, 3'd1);
			end else begin
				tree_cnt <= tree_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/stream_fifo.sv ====
/*
 * Synchronous FIFO with first-word fall-through output.
 * The payload type is a parameter so one block carries lines and sums.
 */
`default_nettype none

module stream_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 4
) (
	input wire clk,
	input wire rst_n,
	input wire payload_t din,
	input wire push,
	output logic full,
	output payload_t dout,
	input wire pop,
	output logic empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Requests against a full or empty buffer are simply ignored
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;
	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the dt_core testbench with Verilator, then check the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dt_core -f vlog.f \
	&& ./obj_dir/Vtb_dt_core > sim.log 2>&1 \
	|| echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

// ==== tests/clock_gen.sv ====
/*
 * Testbench clock and reset generator.
 * Clock period of 4, reset low for the first two rising edges.
 */
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 2;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/dt_core_props.sv ====
/*
 * Handshake properties of the decision-tree core.
 * Bound into dt_core to watch the partial ready bits, the stalled result
 * and the lane beats.
 */
`default_nettype none

module dt_core_props (
	input wire clk,
	input wire rst_n,
	input wire dt_core_pkg::core_mode_e mode,
	input wire dt_core_pkg::lane_beat_t [dt_core_pkg::NUM_CLUSTERS-1:0] lanes,
	input wire dt_core_pkg::cluster_mask_t partial_ready,
	input wire [dt_core_pkg::RESULT_W-1:0] tuple_out,
	input wire tuple_out_valid,
	input wire tuple_out_ready
);

	dt_core_pkg::cluster_mask_t lane_valid;

	always_comb begin
		for (int c = 0; c < dt_core_pkg::NUM_CLUSTERS; c++) begin
			lane_valid[c] = lanes[c].valid;
		end
	end

	// The gatherer offers a ready to one cluster at most
	single_partial_ready: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(partial_ready))
		else $error("more than one partial_ready bit is high");

	stalled_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
		tuple_out_valid && !tuple_out_ready |=> tuple_out_valid && $stable(tuple_out))
		else $error("tuple_out changed or dropped valid while stalled");

	no_beats_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		mode == dt_core_pkg::IDLE |-> lane_valid == '0)
		else $error("lane beat seen while the core is idle");

endmodule

bind dt_core dt_core_props props_inst (
	.clk(clk),
	.rst_n(rst_n),
	.mode(mode),
	.lanes(lanes),
	.partial_ready(partial_ready),
	.tuple_out(tuple_out),
	.tuple_out_valid(tuple_out_valid),
	.tuple_out_ready(tuple_out_ready)
);

`default_nettype wire

// ==== tests/tb_dt_core.sv ====
/*
 * Testbench for the decision-tree core.
 * Random trees and tuples, cluster stand-ins on the lanes and partials,
 * and a queue model of the beats each cluster should see and the sums.
 */
`default_nettype none

module tb_dt_core;

	localparam logic [31:0] SEED = 32'h3396_0069;
	localparam int NUM_SESSIONS = 3;
	localparam int MAX_TREES = 6;
	localparam int MAX_TUPLES = 12;
	localparam int MAX_LINES = NUM_SESSIONS * (MAX_TREES * 3 + MAX_TUPLES * 2);
	localparam int WATCHDOG_CYCLES = 40 * MAX_LINES + 2000;
	localparam int NC = dt_core_pkg::NUM_CLUSTERS;

	logic clk;
	logic rst_n;
	logic start;
	dt_core_pkg::core_cfg_t cfg;
	dt_core_pkg::core_line_t in_line;
	logic in_valid;
	logic in_ready;
	dt_core_pkg::lane_beat_t [NC-1:0] lanes;
	dt_core_pkg::cluster_mask_t lane_ready;
	dt_core_pkg::partial_t [NC-1:0] partials;
	dt_core_pkg::cluster_mask_t partial_ready;
	logic [dt_core_pkg::RESULT_W-1:0] tuple_out;
	logic tuple_out_valid;
	logic tuple_out_ready;

	// Stimulus and model queues
	dt_core_pkg::core_line_t line_q [$];
	dt_core_pkg::lane_beat_t exp_beats [NC][$];
	logic [dt_core_pkg::RESULT_W-1:0] part_q [NC][$];
	logic [dt_core_pkg::RESULT_W-1:0] exp_sums [$];

	// Transfers seen at the falling edge, acted on after the next rising edge
	logic in_fire = 1'b0;
	dt_core_pkg::cluster_mask_t part_fire = '0;
	dt_core_pkg::cluster_mask_t ready_prev = '0;
	logic stall_prev = 1'b0;
	logic [dt_core_pkg::RESULT_W-1:0] stall_val = '0;
	logic preload = 1'b0;
	logic started = 1'b0;
	logic saw_full = 1'b0;
	int occupancy = 0;
	int errors = 0;
	int beats_checked = 0;
	int results_checked = 0;

	clock_gen clock_gen_inst (
		.clk(clk),
		.rst_n(rst_n)
	);

	dt_core dt_core_inst (.*);

	task automatic log_error(input string msg);
		$display("ERROR: %s", msg);
		errors++;
	endtask

	function automatic dt_core_pkg::cluster_mask_t rotate_left(
			input dt_core_pkg::cluster_mask_t m, input int n);
		dt_core_pkg::cluster_mask_t r;
		int i;
		r = m;
		for (i = 0; i < n % NC; i++) begin
			r = {r[NC-2:0], r[NC-1]};
		end
		return r;
	endfunction

	// One line to the FIFO feed, and its two halves to every enabled cluster
	task automatic queue_line(input logic [63:0] data, input logic is_data, input logic last,
			input dt_core_pkg::cluster_mask_t m);
		dt_core_pkg::core_line_t ln;
		dt_core_pkg::lane_beat_t lo;
		dt_core_pkg::lane_beat_t hi;
		int c;
		ln.data = data;
		ln.is_data = is_data;
		ln.last = last;
		lo.half = data[31:0];
		lo.valid = 1'b1;
		lo.is_data = is_data;
		lo.last = 1'b0;
		hi = lo;
		hi.half = data[63:32];
		hi.last = last;
		line_q.push_back(ln);
		for (c = 0; c < NC; c++) begin
			if (m[c]) begin
				exp_beats[c].push_back(lo);
				exp_beats[c].push_back(hi);
			end
		end
	endtask

	task automatic queue_stream(input dt_core_pkg::core_cfg_t c);
		int n_trees;
		int n_tuples;
		int n_lines;
		int cpt;
		int t;
		int l;
		int o;
		logic [31:0] v;
		logic [31:0] total;
		cpt = int'(c.clusters_per_tuple);
		n_trees = $urandom_range(MAX_TREES, 3);
		for (t = 0; t < n_trees; t++) begin
			n_lines = $urandom_range(3, 1);
			for (l = 0; l < n_lines; l++) begin
				queue_line({$urandom, $urandom}, 1'b0, l == n_lines - 1,
					rotate_left(c.prog_schedule, t / dt_core_pkg::PUS_PER_CLUSTER));
			end
		end
		n_tuples = $urandom_range(MAX_TUPLES, 6);
		for (t = 0; t < n_tuples; t++) begin
			n_lines = $urandom_range(2, 1);
			for (l = 0; l < n_lines; l++) begin
				queue_line({$urandom, $urandom}, 1'b1, l == n_lines - 1,
					rotate_left(c.proc_schedule, t * cpt));
			end
			// Partials come from the clusters at base plus offset, base moving by cpt
			total = '0;
			for (o = 0; o < cpt; o++) begin
				v = $urandom;
				part_q[(t * cpt + o) % NC].push_back(v);
				total = total + v;
			end
			exp_sums.push_back(total);
		end
	endtask

	function automatic bit stream_drained();
		bit busy;
		int c;
		busy = (line_q.size() != 0) || (exp_sums.size() != 0);
		for (c = 0; c < NC; c++) begin
			busy = busy || (exp_beats[c].size() != 0);
		end
		return !busy;
	endfunction

	task automatic pulse_start();
		start = 1'b1;
		started = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic run_session(input bit preload_first);
		dt_core_pkg::core_cfg_t next_cfg;
		@(posedge clk);
		#1;
		next_cfg.prog_schedule = 4'($urandom_range(15, 1));
		next_cfg.proc_schedule = 4'($urandom_range(15, 1));
		next_cfg.clusters_per_tuple = 3'($urandom_range(4, 1));
		cfg = next_cfg;
		if (preload_first) begin
			// Fill the input FIFO while the core is still idle
			queue_stream(next_cfg);
			preload = 1'b1;
			repeat (12) @(posedge clk);
			#1;
			preload = 1'b0;
			pulse_start();
		end else begin
			pulse_start();
			repeat (2) @(posedge clk);
			#1;
			queue_stream(next_cfg);
		end
		while (!stream_drained()) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
	endtask

	////////////////////////////////////////
	// Input drivers and cluster stand-ins
	////////////////////////////////////////

	initial begin : drive_inputs
		int c;
		in_valid = 1'b0;
		in_line = '0;
		lane_ready = '0;
		partials = '0;
		tuple_out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (in_fire) begin
				void'(line_q.pop_front());
			end
			in_valid = (line_q.size() != 0) && (preload || $urandom_range(3, 0) != 0);
			in_line = (line_q.size() != 0) ? line_q[0] : '0;
			lane_ready = 4'($urandom_range(15, 0));
			for (c = 0; c < NC; c++) begin
				if (part_fire[c]) begin
					void'(part_q[c].pop_front());
				end
				partials[c].valid = (part_q[c].size() != 0) && ($urandom_range(1, 0) == 1);
				partials[c].value = (part_q[c].size() != 0) ? part_q[c][0] : '0;
			end
			tuple_out_ready = ($urandom_range(2, 0) != 0);
		end
	end

	////////////////////////////////////////
	// Monitor, sampled at the falling edge
	////////////////////////////////////////

	always @(negedge clk) begin : monitor
		dt_core_pkg::lane_beat_t exp;
		dt_core_pkg::cluster_mask_t data_set;
		logic [dt_core_pkg::RESULT_W-1:0] exp_sum;
		int c;
		if (rst_n) begin
			in_fire = in_valid && in_ready;
			for (c = 0; c < NC; c++) begin
				part_fire[c] = partials[c].valid && partial_ready[c];
			end
			data_set = '0;
			for (c = 0; c < NC; c++) begin
				if (lanes[c].valid) begin
					data_set[c] = lanes[c].is_data;
					if (exp_beats[c].size() == 0) begin
						log_error($sformatf("beat on lane %0d that the model does not expect", c));
					end else begin
						exp = exp_beats[c].pop_front();
						beats_checked++;
						if ({lanes[c].half, lanes[c].is_data, lanes[c].last} !=
								{exp.half, exp.is_data, exp.last}) begin
							$display("MISMATCH lanes[%0d]: expected %h actual %h", c,
								{exp.half, exp.is_data, exp.last},
								{lanes[c].half, lanes[c].is_data, lanes[c].last});
							errors++;
						end
					end
				end
			end
			if (data_set != '0 && (data_set & ready_prev) == '0) begin
				log_error("data beat sent while no enabled cluster was ready");
			end
			ready_prev = lane_ready;
			// A stalled result must hold until it is taken
			if (stall_prev && (!tuple_out_valid || tuple_out != stall_val)) begin
				$display("MISMATCH tuple_out (stalled): expected %h actual %h valid %h",
					stall_val, tuple_out, tuple_out_valid);
				errors++;
			end
			if (tuple_out_valid && tuple_out_ready) begin
				if (exp_sums.size() == 0) begin
					log_error("result delivered that the model does not expect");
				end else begin
					exp_sum = exp_sums.pop_front();
					results_checked++;
					if (tuple_out != exp_sum) begin
						$display("MISMATCH tuple_out: expected %h actual %h", exp_sum, tuple_out);
						errors++;
					end
				end
			end
			stall_prev = tuple_out_valid && !tuple_out_ready;
			stall_val = tuple_out;
			// Nothing leaves the input FIFO before the first start
			if (!started) begin
				if (in_ready != (occupancy < dt_core_pkg::IN_FIFO_DEPTH)) begin
					$display("MISMATCH in_ready: expected %h actual %h",
						occupancy < dt_core_pkg::IN_FIFO_DEPTH, in_ready);
					errors++;
				end
				if (!in_ready) begin
					saw_full = 1'b1;
				end
				if (in_fire) begin
					occupancy++;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

	initial begin : main_seq
		int s;
		start = 1'b0;
		cfg = '0;
		void'($urandom(SEED));
		wait (rst_n === 1'b1);
		for (s = 0; s < NUM_SESSIONS; s++) begin
			run_session(s == 0);
		end
		repeat (8) @(posedge clk);
		if (!saw_full) begin
			log_error("in_ready never dropped with the input FIFO full");
		end
		$display("Checked %0d beats and %0d results, %0d errors",
			beats_checked, results_checked, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/dt_core_pkg.sv
hdl/stream_fifo.sv
hdl/core_fsm.sv
hdl/schedule_rotator.sv
hdl/line_distributor.sv
hdl/result_gatherer.sv
hdl/dt_core.sv
tests/clock_gen.sv
tests/dt_core_props.sv
tests/tb_dt_core.sv
